//--- mem_subsys.f
rtl/mem_pkg.sv
rtl/mem_bus_if.sv
rtl/lsu_ext.sv
rtl/mem_stage.sv
rtl/mem_lat_timer.sv
rtl/mem_bus_ctrl.sv
rtl/data_ram.sv
rtl/mem_subsys.sv
bench/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_mem_subsys -f mem_subsys.f -o sim_mem_subsys > build.log 2>&1 \
  && ./obj_dir/sim_mem_subsys > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

//--- bench/tb_mem_subsys.sv
module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 50; // cycles allowed per wait

  logic               clk;
  logic               arst_n_i;
  mem_pkg::xlen_t     inst_addr_i;
  mem_pkg::xlen_t     inst_data_i;
  mem_pkg::reg_idx_t  rd_idx_i;
  mem_pkg::xlen_t     rs2_data_i;
  mem_pkg::memop_e    mem_op_i;
  mem_pkg::xlen_t     alu_data_i;
  mem_pkg::trap_bus_t trap_bus_i;
  mem_pkg::xlen_t     inst_addr_o;
  mem_pkg::xlen_t     inst_data_o;
  mem_pkg::reg_idx_t  rd_idx_o;
  mem_pkg::xlen_t     mem_data_o;
  mem_pkg::trap_bus_t trap_bus_o;
  logic               stall_o;

  logic [7:0]  model_mem [1024]; // byte image of the ram
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  mem_subsys dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected load result straight from the byte image
  function automatic logic [31:0] expect_load(mem_pkg::memop_e op, logic [31:0] addr);
    logic [9:0]  a;
    logic [7:0]  b;
    logic [15:0] h;
    a = addr[9:0];
    b = model_mem[a];
    h = {model_mem[a + 10'd1], model_mem[a]};
    case (op)
      mem_pkg::MEMOP_LB:  return {{24{b[7]}}, b};
      mem_pkg::MEMOP_LBU: return {24'd0, b};
      mem_pkg::MEMOP_LH:  return {{16{h[15]}}, h};
      mem_pkg::MEMOP_LHU: return {16'd0, h};
      default:            return {model_mem[a + 10'd3], model_mem[a + 10'd2], h};
    endcase
  endfunction

  function automatic void model_store(mem_pkg::memop_e op, logic [31:0] addr, logic [31:0] d);
    logic [9:0] a;
    int         n;
    a = addr[9:0];
    n = (op == mem_pkg::MEMOP_SB) ? 1 : (op == mem_pkg::MEMOP_SH) ? 2 : 4;
    for (int k = 0; k < n; k++) begin
      model_mem[a + 10'(k)] = d[8*k +: 8];
    end
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_passthru(input string name, input logic [31:0] ia, input logic [31:0] id,
                                input logic [4:0] rd, input logic [7:0] tr);
    check_val({name, " inst_addr"}, ia, inst_addr_o);
    check_val({name, " inst_data"}, id, inst_data_o);
    check_val({name, " rd_idx"}, {27'd0, rd}, {27'd0, rd_idx_o});
    check_val({name, " trap_bus"}, {24'd0, tr}, {24'd0, trap_bus_o});
  endtask

  // one access, stall counted at each negedge until the ready cycle
  task automatic do_access(input string name, input mem_pkg::memop_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] result);
    logic [31:0] ia;
    logic [31:0] id;
    int          stall_cycles;
    ia = next_rand();
    id = next_rand();
    stall_cycles = 0;
    result = '0;
    @(posedge clk);
    mem_op_i    <= op;
    alu_data_i  <= addr;
    rs2_data_i  <= wdata;
    inst_addr_i <= ia;
    inst_data_i <= id;
    rd_idx_i    <= ia[4:0];
    trap_bus_i  <= id[7:0];
    @(negedge clk);
    while (stall_o !== 1'b0 && stall_cycles < TIMEOUT) begin
      stall_cycles++;
      @(negedge clk);
    end
    if (stall_o !== 1'b0) begin
      $display("%s: stall_o still high after %0d cycles, access never completed", name, TIMEOUT);
      errors++;
    end else begin
      check_val({name, " stall cycles"}, 32'(mem_pkg::MEM_LATENCY + 1), 32'(stall_cycles));
      check_passthru(name, ia, id, ia[4:0], id[7:0]);
      result = mem_data_o;
    end
    @(posedge clk); // edge closing the ready cycle, upstream moves on
    mem_op_i <= mem_pkg::MEMOP_NONE;
  endtask

  task automatic store_op(input string name, input mem_pkg::memop_e op, input logic [31:0] addr,
                          input logic [31:0] d);
    logic [31:0] unused;
    do_access(name, op, addr, d, unused);
    model_store(op, addr, d);
  endtask

  task automatic load_check(input string name, input mem_pkg::memop_e op,
                            input logic [31:0] addr);
    logic [31:0] exp;
    logic [31:0] got;
    exp = expect_load(op, addr);
    do_access(name, op, addr, next_rand(), got);
    check_val(name, exp, got);
  endtask

  task automatic test_noop();
    logic [31:0] v;
    for (int i = 0; i < 5; i++) begin
      v = next_rand();
      @(posedge clk);
      mem_op_i    <= mem_pkg::MEMOP_NONE;
      alu_data_i  <= v;
      inst_addr_i <= ~v;
      inst_data_i <= {v[15:0], v[31:16]};
      rd_idx_i    <= v[9:5];
      trap_bus_i  <= v[23:16];
      @(negedge clk);
      check_val("noop stall", 32'd0, {31'd0, stall_o});
      check_val("noop data", v, mem_data_o);
      check_passthru("noop", ~v, {v[15:0], v[31:16]}, v[9:5], v[23:16]);
    end
  endtask

  task automatic test_word_rw();
    store_op("word_rw sw", mem_pkg::MEMOP_SW, 32'h10, next_rand());
    load_check("word_rw lw", mem_pkg::MEMOP_LW, 32'h10);
  endtask

  task automatic test_byte_rw();
    logic [7:0]  vals [4] = '{8'h81, 8'h7f, 8'hc3, 8'h3c}; // mixed sign bits
    logic [31:0] r;
    store_op("byte_rw init", mem_pkg::MEMOP_SW, 32'h20, next_rand());
    for (int k = 0; k < 4; k++) begin
      r = next_rand();
      store_op("byte_rw sb", mem_pkg::MEMOP_SB, 32'h20 + k, {r[31:8], vals[k]});
      load_check("byte_rw neighbors", mem_pkg::MEMOP_LW, 32'h20);
    end
    for (int k = 0; k < 4; k++) begin
      load_check("byte_rw lb", mem_pkg::MEMOP_LB, 32'h20 + k);
      load_check("byte_rw lbu", mem_pkg::MEMOP_LBU, 32'h20 + k);
    end
  endtask

  task automatic test_half_rw();
    store_op("half_rw init", mem_pkg::MEMOP_SW, 32'h30, next_rand());
    store_op("half_rw sh0", mem_pkg::MEMOP_SH, 32'h30, 32'hdead_7ffe);
    load_check("half_rw neighbor0", mem_pkg::MEMOP_LW, 32'h30); // upper half untouched
    store_op("half_rw sh2", mem_pkg::MEMOP_SH, 32'h32, 32'h1234_8001);
    load_check("half_rw neighbor2", mem_pkg::MEMOP_LW, 32'h30);
    for (int k = 0; k < 4; k += 2) begin
      load_check("half_rw lh", mem_pkg::MEMOP_LH, 32'h30 + k);
      load_check("half_rw lhu", mem_pkg::MEMOP_LHU, 32'h30 + k);
    end
  endtask

  task automatic test_random();
    logic [31:0]     r;
    logic [31:0]     addr;
    mem_pkg::memop_e op;
    for (int w = 0; w < 16; w++) begin
      store_op("random fill", mem_pkg::MEMOP_SW, 32'(4 * w), next_rand()); // 64-byte window
    end
    for (int n = 0; n < 40; n++) begin
      r  = next_rand();
      op = mem_pkg::memop_e'(4'(r[18:16]) + 4'd1); // LB .. SW
      case (op)
        mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LBU, mem_pkg::MEMOP_SB: addr = {26'd0, r[29:24]};
        mem_pkg::MEMOP_LH, mem_pkg::MEMOP_LHU, mem_pkg::MEMOP_SH: addr = {26'd0, r[29:25], 1'b0};
        default: addr = {26'd0, r[29:26], 2'b00};
      endcase
      if (op == mem_pkg::MEMOP_SB || op == mem_pkg::MEMOP_SH || op == mem_pkg::MEMOP_SW) begin
        store_op("random store", op, addr, next_rand());
      end else begin
        load_check("random load", op, addr);
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    arst_n_i    = 1'b0;
    inst_addr_i = '0;
    inst_data_i = '0;
    rd_idx_i    = '0;
    rs2_data_i  = '0;
    mem_op_i    = mem_pkg::MEMOP_NONE;
    alu_data_i  = '0;
    trap_bus_i  = '0;
    lcg_state   = 32'haba0;
    errors      = 0;
    checks      = 0;
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;
    test_noop();
    test_word_rw();
    test_byte_rw();
    test_half_rw();
    test_random();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- rtl/mem_subsys.sv
module mem_subsys (
  input  logic               clk,
  input  logic               arst_n_i,
  // from ex/mem
  input  mem_pkg::xlen_t     inst_addr_i,
  input  mem_pkg::xlen_t     inst_data_i,
  input  mem_pkg::reg_idx_t  rd_idx_i,
  input  mem_pkg::xlen_t     rs2_data_i,
  input  mem_pkg::memop_e    mem_op_i,
  input  mem_pkg::xlen_t     alu_data_i,
  input  mem_pkg::trap_bus_t trap_bus_i,
  // to mem/wb
  output mem_pkg::xlen_t     inst_addr_o,
  output mem_pkg::xlen_t     inst_data_o,
  output mem_pkg::reg_idx_t  rd_idx_o,
  output mem_pkg::xlen_t     mem_data_o,
  output mem_pkg::trap_bus_t trap_bus_o,
  output logic               stall_o
);

  logic timer_start;
  logic timer_expired;
  logic ram_we;

  mem_bus_if bus (); // stage <-> controller/ram

  mem_stage u_stage (
    .inst_addr_i (inst_addr_i),
    .inst_data_i (inst_data_i),
    .rd_idx_i    (rd_idx_i),
    .rs2_data_i  (rs2_data_i),
    .mem_op_i    (mem_op_i),
    .alu_data_i  (alu_data_i),
    .trap_bus_i  (trap_bus_i),
    .inst_addr_o (inst_addr_o),
    .inst_data_o (inst_data_o),
    .rd_idx_o    (rd_idx_o),
    .mem_data_o  (mem_data_o),
    .trap_bus_o  (trap_bus_o),
    .stall_o     (stall_o),
    .bus         (bus.stage)
  );

  mem_bus_ctrl u_ctrl (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .bus             (bus.mem),
    .timer_start_o   (timer_start),
    .timer_expired_i (timer_expired),
    .ram_we_o        (ram_we)
  );

  mem_lat_timer u_timer (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .start_i   (timer_start),
    .expired_o (timer_expired)
  );

  data_ram u_ram (
    .clk  (clk),
    .we_i (ram_we),
    .bus  (bus.mem)
  );

endmodule

//--- rtl/data_ram.sv
module data_ram (
  input  logic   clk,
  input  logic   we_i, // from the bus controller
  mem_bus_if.mem bus
);

  mem_pkg::xlen_t              mem_q [mem_pkg::RAM_WORDS]; // no reset, contents undefined
  logic [mem_pkg::RAM_AW-1:0] word_idx;

  // word index from byte address, upper bits alias
  assign word_idx = bus.addr[mem_pkg::RAM_AW+1:2];

  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.mask[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8]; // enabled lanes only
        end
      end
    end
  end

  // async read, stage picks the lane
  assign bus.rdata = mem_q[word_idx];

endmodule

//--- rtl/mem_bus_ctrl.sv
module mem_bus_ctrl (
  input  logic   clk,
  input  logic   arst_n_i,
  mem_bus_if.mem bus,
  output logic   timer_start_o,   // kick the latency timer
  input  logic   timer_expired_i,
  output logic   ram_we_o         // write strobe for data_ram
);

  mem_pkg::bus_state_e state_q;
  mem_pkg::bus_state_e state_d;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mem_pkg::BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    timer_start_o = 1'b0;
    case (state_q)
      mem_pkg::BUS_IDLE: begin
        if (bus.addr_valid) begin
          timer_start_o = 1'b1;
          state_d       = mem_pkg::BUS_WAIT;
        end
      end
      mem_pkg::BUS_WAIT: begin
        if (timer_expired_i) begin
          state_d = mem_pkg::BUS_DONE;
        end
      end
      mem_pkg::BUS_DONE: begin
        // single ready cycle, stage drops its request now
        state_d = mem_pkg::BUS_IDLE;
      end
      default: begin
        state_d = mem_pkg::BUS_IDLE;
      end
    endcase
  end

  assign bus.data_ready = (state_q == mem_pkg::BUS_DONE);
  // store commits on the edge closing the ready cycle
  assign ram_we_o = (state_q == mem_pkg::BUS_DONE) & bus.write;

endmodule

//--- rtl/mem_lat_timer.sv
module mem_lat_timer (
  input  logic clk,
  input  logic arst_n_i,
  input  logic start_i,   // reload
  output logic expired_o  // last wait cycle
);

  logic [mem_pkg::LAT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= mem_pkg::LAT_W'(mem_pkg::MEM_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1; // stick at zero
    end
  end

  // high on the count of one, so the next edge ends the wait
  assign expired_o = (cnt_q == mem_pkg::LAT_W'(1));

endmodule

//--- rtl/mem_stage.sv
module mem_stage (
  // from ex/mem
  input  mem_pkg::xlen_t    inst_addr_i,
  input  mem_pkg::xlen_t    inst_data_i,
  input  mem_pkg::reg_idx_t rd_idx_i,
  input  mem_pkg::xlen_t    rs2_data_i,  // store source
  input  mem_pkg::memop_e   mem_op_i,
  input  mem_pkg::xlen_t    alu_data_i,  // address or plain result
  input  mem_pkg::trap_bus_t trap_bus_i,
  // to mem/wb
  output mem_pkg::xlen_t    inst_addr_o,
  output mem_pkg::xlen_t    inst_data_o,
  output mem_pkg::reg_idx_t rd_idx_o,
  output mem_pkg::xlen_t    mem_data_o,
  output mem_pkg::trap_bus_t trap_bus_o,
  output logic              stall_o,     // hold upstream while pending
  mem_bus_if.stage          bus
);

  logic op_none;
  logic is_load;
  logic is_store;
  logic ls_signed;
  mem_pkg::size_t     ls_size;
  mem_pkg::byte_mask_t base_mask;
  mem_pkg::byte_mask_t wmask;
  logic [1:0]         addr_off;   // byte offset inside the word
  mem_pkg::xlen_t     st_narrow;  // rs2 cut to access size
  mem_pkg::xlen_t     rdata_sel;
  mem_pkg::xlen_t     rdata_sh;
  mem_pkg::xlen_t     ld_ext;

  // straight through
  assign inst_addr_o = inst_addr_i;
  assign inst_data_o = inst_data_i;
  assign rd_idx_o    = rd_idx_i;
  assign trap_bus_o  = trap_bus_i;

  // op decode
  assign op_none  = (mem_op_i == mem_pkg::MEMOP_NONE);
  assign is_load  = (mem_op_i == mem_pkg::MEMOP_LB) | (mem_op_i == mem_pkg::MEMOP_LBU)
                  | (mem_op_i == mem_pkg::MEMOP_LH) | (mem_op_i == mem_pkg::MEMOP_LHU)
                  | (mem_op_i == mem_pkg::MEMOP_LW);
  assign is_store = (mem_op_i == mem_pkg::MEMOP_SB) | (mem_op_i == mem_pkg::MEMOP_SH)
                  | (mem_op_i == mem_pkg::MEMOP_SW);
  assign ls_signed = (mem_op_i == mem_pkg::MEMOP_LB) | (mem_op_i == mem_pkg::MEMOP_LH)
                   | (mem_op_i == mem_pkg::MEMOP_LW);

  assign ls_size[0] = (mem_op_i == mem_pkg::MEMOP_LB) | (mem_op_i == mem_pkg::MEMOP_LBU)
                    | (mem_op_i == mem_pkg::MEMOP_SB);
  assign ls_size[1] = (mem_op_i == mem_pkg::MEMOP_LH) | (mem_op_i == mem_pkg::MEMOP_LHU)
                    | (mem_op_i == mem_pkg::MEMOP_SH);
  assign ls_size[2] = (mem_op_i == mem_pkg::MEMOP_LW) | (mem_op_i == mem_pkg::MEMOP_SW);
  assign ls_size[3] = 1'b0; // no doubleword on rv32

  // lane masks
  assign base_mask = ({4{ls_size[0]}} & 4'b0001)
                   | ({4{ls_size[1]}} & 4'b0011)
                   | ({4{ls_size[2]}} & 4'b1111);
  assign addr_off  = alu_data_i[1:0];
  assign wmask     = base_mask << addr_off; // misaligned spill is dropped

  // request side
  assign bus.addr       = op_none ? mem_pkg::PC_RESET_ADDR : alu_data_i;
  assign bus.addr_valid = (is_load | is_store) & ~bus.data_ready; // level req
  assign bus.write      = is_store; // held through the ready cycle for the ram strobe
  assign bus.mask       = is_store ? wmask : base_mask;
  assign bus.size       = ls_size;
  assign bus.wdata      = st_narrow << {addr_off, 3'b000};

  assign stall_o = bus.addr_valid;

  lsu_ext u_ext_store (
    .ext_data_i  (rs2_data_i),
    .ls_signed_i (1'b0),        // zero fill, upper lanes masked anyway
    .ls_size_i   (ls_size),
    .ext_data_o  (st_narrow)
  );

  // load path: bring the addressed lane down to bit 0
  assign rdata_sel = bus.data_ready ? bus.rdata : '0;
  assign rdata_sh  = rdata_sel >> {addr_off, 3'b000};

  lsu_ext u_ext_load (
    .ext_data_i  (rdata_sh),
    .ls_signed_i (ls_signed),
    .ls_size_i   (ls_size),
    .ext_data_o  (ld_ext)
  );

  always_comb begin
    if (is_load) begin
      mem_data_o = ld_ext;
    end else if (op_none) begin
      mem_data_o = alu_data_i; // non memory op, alu result
    end else begin
      mem_data_o = '0;         // stores write nothing back
    end
  end

endmodule

//--- rtl/lsu_ext.sv
module lsu_ext (
  input  mem_pkg::xlen_t ext_data_i,  // value sitting at bit 0
  input  logic           ls_signed_i, // 1: sign extend, 0: zero fill
  input  mem_pkg::size_t ls_size_i,   // one-hot byte/half/word
  output mem_pkg::xlen_t ext_data_o
);

  logic byte_sign; // msb of the low byte
  logic half_sign; // msb of the low half

  assign byte_sign = ls_signed_i & ext_data_i[7];
  assign half_sign = ls_signed_i & ext_data_i[15];

  always_comb begin
    if (ls_size_i[0]) begin
      ext_data_o = {{24{byte_sign}}, ext_data_i[7:0]};
    end else if (ls_size_i[1]) begin
      ext_data_o = {{16{half_sign}}, ext_data_i[15:0]};
    end else begin
      // word or no access, nothing to fill
      ext_data_o = ext_data_i;
    end
  end

endmodule

//--- rtl/mem_bus_if.sv
interface mem_bus_if;

  mem_pkg::xlen_t      addr;       // byte address
  logic                addr_valid; // request pending
  logic                write;      // store when high
  mem_pkg::byte_mask_t mask;       // active lanes
  mem_pkg::size_t      size;       // one-hot access size
  mem_pkg::xlen_t      wdata;      // lane aligned store data
  mem_pkg::xlen_t      rdata;      // raw ram word
  logic                data_ready; // one-cycle completion pulse

  // pipeline side
  modport stage (
    output addr, addr_valid, write, mask, size, wdata,
    input  rdata, data_ready
  );

  // controller + ram side, each drives only its own outputs
  modport mem (
    input  addr, addr_valid, write, mask, size, wdata,
    output rdata, data_ready
  );

endinterface

//--- rtl/mem_pkg.sv
package mem_pkg;

  // basic widths
  typedef logic [31:0] xlen_t;      // data / address word
  typedef logic [4:0]  reg_idx_t;   // rd index
  typedef logic [3:0]  byte_mask_t; // one bit per byte lane
  typedef logic [3:0]  size_t;      // one-hot: [0] byte, [1] half, [2] word

  localparam int unsigned TRAP_LEN = 8;
  typedef logic [TRAP_LEN-1:0] trap_bus_t; // forwarded untouched

  // load/store op code from ex/mem
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } memop_e;

  typedef enum logic [1:0] {
    BUS_IDLE = 2'd0,
    BUS_WAIT = 2'd1, // timer running
    BUS_DONE = 2'd2  // ready pulse
  } bus_state_e;

  localparam int unsigned MEM_LATENCY = 2;                        // wait cycles, >= 1
  localparam int unsigned LAT_W       = $clog2(MEM_LATENCY + 1); // timer width
  localparam int unsigned RAM_WORDS   = 256;
  localparam int unsigned RAM_AW      = 8;                        // word index bits
  localparam xlen_t       PC_RESET_ADDR = 32'h8000_0000;          // idle address

endpackage
